// ==== vWriteBusPkg.sv ====
package vWriteBusPkg;

   // system bus byte address
   localparam int ioAddrW = 32;

   // one stream word, one memory word, one bus beat
   localparam int dataW = 32;

   typedef logic [dataW-1:0] dataT;

   // write request on the data bus
   typedef struct packed {
      logic [ioAddrW-1:0] addr;
      dataT               wdata;
      logic [dataW/8-1:0] wstrb;
   } busReqT;

endpackage

// ==== vWriteCfgPkg.sv ====
package vWriteCfgPkg;

   import vWriteBusPkg::*;

   // 1024 words of local memory
   localparam int memAddrW = 10;

   // period, duty and delay counts
   localparam int periodW = 10;

   // one extra bit so a full memory fits in the drain size
   localparam int ioSizeW = memAddrW + 1;

   // store side, two-level address generator
   typedef struct packed {
      logic [memAddrW-1:0] iterations;
      logic [periodW-1:0]  period;
      logic [periodW-1:0]  duty;
      logic [periodW-1:0]  delay;
      logic [memAddrW-1:0] start;
      logic [memAddrW-1:0] shift;
      logic [memAddrW-1:0] incr;
      logic [memAddrW-1:0] iterations2;
      logic [memAddrW-1:0] shift2;
      logic                reverse;
   } storeCfgT;

   // drain side, linear block to system memory
   typedef struct packed {
      logic [ioAddrW-1:0]  extAddr;
      logic [memAddrW-1:0] intAddr;
      logic [ioSizeW-1:0]  size;
   } drainCfgT;

   // whole configuration word
   typedef struct packed {
      storeCfgT store;
      drainCfgT drain;
   } vWriteCfgT;

endpackage

// ==== localRam.sv ====
module localRam
(
   input  logic                               clk,
   input  logic                               rdEn,
   input  logic [vWriteCfgPkg::memAddrW-1:0]  rdAddr,
   output vWriteBusPkg::dataT                 rdData,
   input  logic                               wrEn,
   input  logic [vWriteCfgPkg::memAddrW-1:0]  wrAddr,
   input  vWriteBusPkg::dataT                 wrData
);

   import vWriteCfgPkg::*;
   import vWriteBusPkg::*;

   dataT mem [2**memAddrW];

   // read before write on a shared address
   always_ff @(posedge clk)
   begin
      if (wrEn)
      begin
         mem[wrAddr] <= wrData;
      end
      if (rdEn)
      begin
         rdData <= mem[rdAddr];
      end
   end

endmodule

// ==== storeAddrGen.sv ====
module storeAddrGen
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run,
   input  vWriteCfgPkg::storeCfgT            cfg,
   output logic [vWriteCfgPkg::memAddrW-1:0] addr,
   output logic                              memEn,
   output logic                              done
);

   import vWriteCfgPkg::*;

   logic                active;
   logic                doneReg;
   logic [periodW-1:0]  delayCnt;
   logic [periodW-1:0]  perCnt;
   logic [memAddrW-1:0] iterCnt;
   logic [memAddrW-1:0] iter2Cnt;
   logic [memAddrW-1:0] addrReg;
   logic [memAddrW-1:0] addrNext;
   logic                emptyLoop;
   logic                step;
   logic                lastPer;
   logic                lastIter;
   logic                lastIter2;

   // nothing to store when either loop count is zero
   assign emptyLoop = (cfg.iterations == '0) || (cfg.iterations2 == '0);

   assign step = active && (delayCnt == '0);

   // a zero period behaves as one
   assign lastPer = (perCnt + periodW'(1)) >= cfg.period;
   assign lastIter = (iterCnt + memAddrW'(1)) >= cfg.iterations;
   assign lastIter2 = (iter2Cnt + memAddrW'(1)) >= cfg.iterations2;

   assign memEn = step && (perCnt < cfg.duty);
   assign addr = addrReg;

   // all three steps add up, wrapping at the memory depth
   always_comb
   begin
      addrNext = addrReg;
      if (memEn)
      begin
         addrNext = addrNext + cfg.incr;
      end
      if (lastPer)
      begin
         addrNext = addrNext + cfg.shift;
      end
      if (lastPer && lastIter)
      begin
         addrNext = addrNext + cfg.shift2;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         active <= 1'b0;
         doneReg <= 1'b1;
         delayCnt <= '0;
         perCnt <= '0;
         iterCnt <= '0;
         iter2Cnt <= '0;
         addrReg <= '0;
      end
      else if (run)
      begin
         active <= !emptyLoop;
         doneReg <= emptyLoop;
         delayCnt <= cfg.delay;
         perCnt <= '0;
         iterCnt <= '0;
         iter2Cnt <= '0;
         addrReg <= cfg.start;
      end
      else if (active)
      begin
         if (!step)
         begin
            delayCnt <= delayCnt - periodW'(1);
         end
         else
         begin
            addrReg <= addrNext;
            if (!lastPer)
            begin
               perCnt <= perCnt + periodW'(1);
            end
            else
            begin
               perCnt <= '0;
               if (!lastIter)
               begin
                  iterCnt <= iterCnt + memAddrW'(1);
               end
               else
               begin
                  iterCnt <= '0;
                  if (lastIter2)
                  begin
                     active <= 1'b0;
                     doneReg <= 1'b1;
                  end
                  else
                  begin
                     iter2Cnt <= iter2Cnt + memAddrW'(1);
                  end
               end
            end
         end
      end
   end

   // low in the run cycle itself
   assign done = doneReg && !run;

   noWriteWhenDone: assert property (@(posedge clk) disable iff (rst) memEn |-> !done)
      else $error("store write enabled after done");

endmodule

// ==== extWriteEngine.sv ====
module extWriteEngine
(
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run,
   input  vWriteCfgPkg::drainCfgT            cfg,
   output logic                              done,
   output logic                              rdEn,
   output logic [vWriteCfgPkg::memAddrW-1:0] rdAddr,
   input  vWriteBusPkg::dataT                rdData,
   output logic                              busValid,
   input  logic                              busReady,
   output vWriteBusPkg::busReqT              busReq
);

   import vWriteCfgPkg::*;
   import vWriteBusPkg::*;

   typedef enum logic [1:0] {sIdle, sRead, sWait, sReq} stateT;

   stateT               state;
   logic                doneReg;
   logic [ioSizeW-1:0]  remaining;
   logic [memAddrW-1:0] rdAddrReg;
   logic [ioAddrW-1:0]  extCur;

   assign rdEn = (state == sRead);
   assign rdAddr = rdAddrReg;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= sIdle;
         doneReg <= 1'b1;
         busValid <= 1'b0;
         remaining <= '0;
         rdAddrReg <= '0;
         extCur <= '0;
      end
      else
      begin
         case (state)
            sIdle:
            begin
               if (run)
               begin
                  remaining <= cfg.size;
                  rdAddrReg <= cfg.intAddr;
                  extCur <= cfg.extAddr;
                  if (cfg.size == '0)
                  begin
                     doneReg <= 1'b1;
                  end
                  else
                  begin
                     doneReg <= 1'b0;
                     state <= sRead;
                  end
               end
            end
            // memory data arrives one cycle after the read
            sRead:
            begin
               state <= sWait;
            end
            sWait:
            begin
               busValid <= 1'b1;
               state <= sReq;
            end
            sReq:
            begin
               if (busReady)
               begin
                  busValid <= 1'b0;
                  remaining <= remaining - ioSizeW'(1);
                  rdAddrReg <= rdAddrReg + memAddrW'(1);
                  extCur <= extCur + ioAddrW'(4);
                  if (remaining == ioSizeW'(1))
                  begin
                     doneReg <= 1'b1;
                     state <= sIdle;
                  end
                  else
                  begin
                     state <= sRead;
                  end
               end
            end
            default:
            begin
               state <= sIdle;
            end
         endcase
      end
   end

   // request payload, loaded once per word
   always_ff @(posedge clk)
   begin
      if (state == sWait)
      begin
         busReq.addr <= extCur;
         busReq.wdata <= rdData;
         busReq.wstrb <= '1;
      end
   end

   assign done = doneReg && !run;

   reqStable: assert property (@(posedge clk) disable iff (rst)
      busValid && !busReady |=> busValid && $stable(busReq))
      else $error("bus request changed while waiting for ready");

endmodule

// ==== cfgShadow.sv ====
module cfgShadow
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     cfgValid,
   output logic                     cfgReady,
   input  vWriteCfgPkg::vWriteCfgT  cfg,
   input  logic                     done,
   output logic                     run,
   output vWriteCfgPkg::vWriteCfgT  cfgHeld
);

   import vWriteCfgPkg::*;

   logic busy;
   logic accept;

   assign accept = cfgValid && cfgReady;
   assign cfgReady = !busy;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         run <= 1'b0;
      end
      else
      begin
         run <= accept;
         if (accept)
         begin
            busy <= 1'b1;
         end
         // done is masked during the run cycle, so the first high is the real end
         else if (busy && !run && done)
         begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         cfgHeld <= cfg;
      end
   end

   runPulse: assert property (@(posedge clk) disable iff (rst) run |=> !run)
      else $error("run held for more than one cycle");

endmodule

// ==== vWrite.sv ====
module vWrite
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  vWriteCfgPkg::vWriteCfgT cfg,
   input  vWriteBusPkg::dataT      in0,
   output logic                    done,
   output logic                    busValid,
   input  logic                    busReady,
   output vWriteBusPkg::busReqT    busReq
);

   import vWriteCfgPkg::*;
   import vWriteBusPkg::*;

   logic [memAddrW-1:0] genAddr;
   logic [memAddrW-1:0] wrAddr;
   logic [memAddrW-1:0] rdAddr;
   logic                memEn;
   logic                rdEn;
   logic                storeDone;
   logic                drainDone;
   dataT                rdData;

   function automatic logic [memAddrW-1:0] reverseBits(input logic [memAddrW-1:0] word);
      logic [memAddrW-1:0] result;
      for (int i = 0; i < memAddrW; i++)
      begin
         result[i] = word[memAddrW-1-i];
      end
      return result;
   endfunction

   storeAddrGen i_storeAddrGen
   (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .cfg    (cfg.store),
      .addr   (genAddr),
      .memEn  (memEn),
      .done   (storeDone)
   );

   // FFT-style ordering on the store side
   assign wrAddr = cfg.store.reverse ? reverseBits(genAddr) : genAddr;

   localRam i_localRam
   (
      .clk    (clk),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData),
      .wrEn   (memEn),
      .wrAddr (wrAddr),
      .wrData (in0)
   );

   extWriteEngine i_extWriteEngine
   (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfg.drain),
      .done     (drainDone),
      .rdEn     (rdEn),
      .rdAddr   (rdAddr),
      .rdData   (rdData),
      .busValid (busValid),
      .busReady (busReady),
      .busReq   (busReq)
   );

   // both sides have to finish
   assign done = storeDone && drainDone;

endmodule

// ==== vWriteTop.sv ====
module vWriteTop
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cfgValid,
   output logic                    cfgReady,
   input  vWriteCfgPkg::vWriteCfgT cfg,
   input  vWriteBusPkg::dataT      in0,
   output logic                    done,
   output logic                    busValid,
   input  logic                    busReady,
   output vWriteBusPkg::busReqT    busReq
);

   import vWriteCfgPkg::*;

   vWriteCfgT cfgHeld;
   logic      run;

   cfgShadow i_cfgShadow
   (
      .clk      (clk),
      .rst      (rst),
      .cfgValid (cfgValid),
      .cfgReady (cfgReady),
      .cfg      (cfg),
      .done     (done),
      .run      (run),
      .cfgHeld  (cfgHeld)
   );

   vWrite i_vWrite
   (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .cfg      (cfgHeld),
      .in0      (in0),
      .done     (done),
      .busValid (busValid),
      .busReady (busReady),
      .busReq   (busReq)
   );

endmodule

// ==== tbVWriteTop.sv ====
module tbVWriteTop;

   import vWriteCfgPkg::*;
   import vWriteBusPkg::*;

   localparam int numRuns = 7;
   localparam int maxCycles = 2000 * numRuns + 100;

   logic      clk;
   logic      rst;
   logic      cfgValid;
   logic      cfgReady;
   vWriteCfgT cfg;
   dataT      in0;
   logic      done;
   logic      busValid;
   logic      busReady;
   busReqT    busReq;

   vWriteCfgT runTable [numRuns];
   dataT      model [2**memAddrW];
   busReqT    expected [$];
   int        hsTotal;

   vWriteTop i_vWriteTop
   (
      .clk      (clk),
      .rst      (rst),
      .cfgValid (cfgValid),
      .cfgReady (cfgReady),
      .cfg      (cfg),
      .in0      (in0),
      .done     (done),
      .busValid (busValid),
      .busReady (busReady),
      .busReq   (busReq)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   // bus side accepts about 7 cycles in 10
   always @(posedge clk)
   begin
      busReady <= ($urandom % 10) < 7;
   end

   // stream counter restarting at zero in the run cycle
   always @(posedge clk)
   begin
      if (cfgValid && cfgReady)
         in0 <= '0;
      else
         in0 <= in0 + dataT'(1);
   end

   task automatic failNow();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic checkBusReq(input busReqT got, input busReqT want);
      if (got !== want)
      begin
         $display("Error at time %0t: busReq expected %h %h %h, got %h %h %h", $time,
            want.addr, want.wdata, want.wstrb, got.addr, got.wdata, got.wstrb);
         failNow();
      end
   endtask

   task automatic checkCount(input logic [ioSizeW-1:0] got, input logic [ioSizeW-1:0] want);
      if (got !== want)
      begin
         $display("Error at time %0t: handshake count expected %0d, got %0d", $time, want, got);
         failNow();
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic want);
      if (got !== want)
      begin
         $display("Error at time %0t: %s expected %b, got %b", $time, name, want, got);
         failNow();
      end
   endtask

   // checks every bus handshake against the queued words
   always @(posedge clk)
   begin
      if (rst)
         hsTotal <= 0;
      else if (busValid && busReady)
      begin
         if (expected.size() == 0)
         begin
            $display("Bus handshake at time %0t with no word left to drain", $time);
            failNow();
         end
         else
         begin
            checkBusReq(busReq, expected.pop_front());
            hsTotal <= hsTotal + 1;
         end
      end
   end

   function automatic logic [memAddrW-1:0] mirrorAddr(input logic [memAddrW-1:0] a);
      logic [memAddrW-1:0] m;
      m = '0;
      for (int b = 0; b < memAddrW; b++)
      begin
         m = {m[memAddrW-2:0], a[b]};
      end
      return m;
   endfunction

   function automatic storeCfgT storeSpec(input int iter, input int per, input int duty,
      input int delay, input int start, input int shift, input int incr, input int iter2,
      input int shift2, input logic rev);
      storeCfgT s;
      s.iterations = memAddrW'(iter);
      s.period = periodW'(per);
      s.duty = periodW'(duty);
      s.delay = periodW'(delay);
      s.start = memAddrW'(start);
      s.shift = memAddrW'(shift);
      s.incr = memAddrW'(incr);
      s.iterations2 = memAddrW'(iter2);
      s.shift2 = memAddrW'(shift2);
      s.reverse = rev;
      return s;
   endfunction

   function automatic drainCfgT drainSpec(input logic [ioAddrW-1:0] ext, input int intAddr,
      input int size);
      drainCfgT d;
      d.extAddr = ext;
      d.intAddr = memAddrW'(intAddr);
      d.size = ioSizeW'(size);
      return d;
   endfunction

   // word written at step cycle t is t itself
   task automatic storeModel(input storeCfgT s);
      logic [memAddrW-1:0] a;
      int t;
      int per;
      a = s.start;
      t = int'(s.delay) + 1;
      per = (s.period == '0) ? 1 : int'(s.period);
      for (int o = 0; o < int'(s.iterations2); o++)
      begin
         for (int i = 0; i < int'(s.iterations); i++)
         begin
            for (int p = 0; p < per; p++)
            begin
               if (p < int'(s.duty))
               begin
                  model[s.reverse ? mirrorAddr(a) : a] = dataT'(t);
                  a = a + s.incr;
               end
               t++;
            end
            a = a + s.shift;
         end
         a = a + s.shift2;
      end
   endtask

   task automatic queueDrain(input drainCfgT d);
      busReqT req;
      logic [memAddrW-1:0] a;
      a = d.intAddr;
      for (int k = 0; k < int'(d.size); k++)
      begin
         req.addr = d.extAddr + ioAddrW'(4 * k);
         req.wdata = model[a];
         req.wstrb = '1;
         expected.push_back(req);
         a = a + memAddrW'(1);
      end
   endtask

   // cfgValid stays up during the run, so a busy unit is offered a config
   task automatic applyRun(input vWriteCfgT c);
      int hsStart;
      cfg <= c;
      cfgValid <= 1'b1;
      @(posedge clk);
      while (!(cfgValid && cfgReady))
         @(posedge clk);
      hsStart = hsTotal;
      queueDrain(c.drain);
      storeModel(c.store);
      @(posedge clk);
      checkFlag("done", done, 1'b0);
      while (!done)
      begin
         checkFlag("cfgReady", cfgReady, 1'b0);
         @(posedge clk);
      end
      cfgValid <= 1'b0;
      checkFlag("cfgReady", cfgReady, 1'b0);
      checkCount(ioSizeW'(hsTotal - hsStart), c.drain.size);
      @(posedge clk);
      checkFlag("cfgReady", cfgReady, 1'b1);
   endtask

   initial
   begin
      void'($urandom(32'hb9a9_9730));
      rst = 1'b1;
      cfgValid = 1'b0;
      cfg = '0;
      in0 = '0;
      busReady = 1'b0;
      // store fields are iter per duty delay start shift incr iter2 shift2 rev
      runTable[0] = {storeSpec(0, 1, 1, 0, 0, 0, 0, 0, 0, 0), drainSpec(32'h0000_1000, 0, 0)};
      runTable[1] = {storeSpec(256, 1, 1, 0, 0, 0, 1, 4, 0, 0), drainSpec(32'h0000_1000, 0, 0)};
      runTable[2] = {storeSpec(5, 4, 3, 3, 200, 2, 1, 1, 0, 0),
         drainSpec(32'h1000_0000, 600, 8)};
      runTable[3] = {storeSpec(3, 2, 2, 1, 1010, 1, 3, 3, 7, 0),
         drainSpec(32'h2000_0040, 198, 28)};
      // wraps past the top of memory
      runTable[4] = {storeSpec(0, 1, 1, 0, 0, 0, 0, 0, 0, 0),
         drainSpec(32'h3000_0ff0, 1008, 80)};
      runTable[5] = {storeSpec(2, 8, 8, 2, 0, 0, 1, 1, 0, 1), drainSpec(32'h3800_0000, 700, 4)};
      runTable[6] = {storeSpec(2, 3, 1, 5, 900, 1, 4, 1, 0, 0),
         drainSpec(32'h4000_0000, 0, 260)};
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      checkFlag("done", done, 1'b1);
      checkFlag("cfgReady", cfgReady, 1'b1);
      checkFlag("busValid", busValid, 1'b0);
      for (int r = 0; r < numRuns; r++)
      begin
         applyRun(runTable[r]);
      end
      $display("TEST PASSED");
      $finish;
   end

   initial
   begin
      repeat (maxCycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run hung", maxCycles);
      failNow();
   end

endmodule

// ==== vWriteTop.f ====
vWriteBusPkg.sv
vWriteCfgPkg.sv
localRam.sv
storeAddrGen.sv
extWriteEngine.sv
cfgShadow.sv
vWrite.sv
vWriteTop.sv
tbVWriteTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbVWriteTop
FILELIST  ?= vWriteTop.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
